//--- Bender.yml
package:
  name: uart_tx

sources:
  - common/uart_tx_pkg.sv
  - hw/uart_baud_controller.sv
  - uart_tx/uart_tx_framer.sv
  - uart_tx/uart_tx_shifter.sv
  - hw/uart_tx_top.sv
  - target: test
    files:
      - testbench/uart_tx_assert.sv
      - testbench/uart_tx_tb.sv

//--- build.f
common/uart_tx_pkg.sv
hw/uart_baud_controller.sv
uart_tx/uart_tx_framer.sv
uart_tx/uart_tx_shifter.sv
hw/uart_tx_top.sv
testbench/uart_tx_assert.sv
testbench/uart_tx_tb.sv

//--- common/uart_tx_pkg.sv
package uart_tx_pkg;

	localparam int frame_bits = 11; // Start, eight data, parity, stop
	localparam int ticks_per_bit = 16;

	typedef enum logic [2:0] {
		baud_300 = 3'd0,
		baud_1200 = 3'd1,
		baud_2400 = 3'd2,
		baud_4800 = 3'd3,
		baud_9600 = 3'd4,
		baud_19200 = 3'd5,
		baud_57600 = 3'd6,
		baud_115200 = 3'd7
	} baud_rate_e;

	typedef enum logic {
		idle = 1'b0,
		sending = 1'b1
	} tx_state_e;

	typedef struct packed {
		logic valid; // High for one cycle when a new frame is ready
		logic [frame_bits-1:0] bits; // Bit 0 goes out first
	} tx_frame_t;

	function automatic int unsigned baud_rate_value(input baud_rate_e rate);
		case (rate)
			baud_300: return 300;
			baud_1200: return 1200;
			baud_2400: return 2400;
			baud_4800: return 4800;
			baud_9600: return 9600;
			baud_19200: return 19200;
			baud_57600: return 57600;
			baud_115200: return 115200;
			default: return 115200;
		endcase
	endfunction

	// Clock cycles between two sampling ticks
	function automatic int unsigned baud_divisor(input int unsigned clk_hz,
			input baud_rate_e rate);
		int unsigned divisor;
		divisor = clk_hz / (ticks_per_bit * baud_rate_value(rate));
		if (divisor < 1) begin
			divisor = 1; // Clock too slow for this rate, tick every cycle
		end
		return divisor;
	endfunction

endpackage

//--- hw/uart_baud_controller.sv
`timescale 1ns/1ps

module uart_baud_controller #(
	parameter int unsigned clk_hz = 1_843_200
) (
	input logic clk,
	input logic reset,
	input uart_tx_pkg::baud_rate_e baud_select,
	output logic sample_tick
);

	import uart_tx_pkg::*;

	// Divisors indexed by select code, worked out at elaboration
	localparam int unsigned div_table [8] = '{
		baud_divisor(clk_hz, baud_300),
		baud_divisor(clk_hz, baud_1200),
		baud_divisor(clk_hz, baud_2400),
		baud_divisor(clk_hz, baud_4800),
		baud_divisor(clk_hz, baud_9600),
		baud_divisor(clk_hz, baud_19200),
		baud_divisor(clk_hz, baud_57600),
		baud_divisor(clk_hz, baud_115200)
	};

	// The slowest rate has the largest divisor and sets the counter width
	localparam int count_w = $clog2(div_table[0] + 1);

	logic [count_w-1:0] count;
	logic [count_w-1:0] reload;
	baud_rate_e select_q;

	assign reload = count_w'(div_table[baud_select] - 1);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
			sample_tick <= 1'b0;
			select_q <= baud_300;
		end else if (baud_select != select_q) begin
			select_q <= baud_select; // New rate, start a fresh period
			count <= reload;
			sample_tick <= 1'b0;
		end else if (count == '0) begin
			count <= reload;
			sample_tick <= 1'b1;
		end else begin
			count <= count - 1'b1;
			sample_tick <= 1'b0;
		end
	end

endmodule

//--- hw/uart_tx_top.sv
`timescale 1ns/1ps

module uart_tx_top #(
	parameter int unsigned clk_hz = 1_843_200
) (
	input logic clk,
	input logic reset,
	input logic [7:0] data,
	input logic write,
	input logic enable,
	input uart_tx_pkg::baud_rate_e baud_select,
	output logic tx,
	output logic busy
);

	import uart_tx_pkg::*;

	logic sample_tick;
	tx_frame_t frame;

	uart_baud_controller #(
		.clk_hz(clk_hz)
	) uart_baud_controller_0 (
		.clk(clk),
		.reset(reset),
		.baud_select(baud_select),
		.sample_tick(sample_tick)
	);

	// Busy goes back to the framer so writes during a frame are dropped
	uart_tx_framer uart_tx_framer_0 (
		.clk(clk),
		.reset(reset),
		.data(data),
		.write(write),
		.busy(busy),
		.frame(frame)
	);

	uart_tx_shifter uart_tx_shifter_0 (
		.clk(clk),
		.reset(reset),
		.frame(frame),
		.enable(enable),
		.sample_tick(sample_tick),
		.tx(tx),
		.busy(busy)
	);

endmodule

//--- testbench/uart_tx_assert.sv
`timescale 1ns/1ps

module uart_tx_assert (
	input logic clk,
	input logic reset,
	input logic write,
	input logic busy,
	input logic tx
);

	int fail_count = 0; // Read by the testbench

	// An idle line rests at the stop level
	line_idle_high: assert property (@(posedge clk) disable iff (reset) !busy |-> tx)
		else begin
			fail_count++;
			$error("tx is low while busy is low");
		end

	busy_holds_on_low_tx: assert property (@(posedge clk) disable iff (reset)
		(busy && !tx) |=> busy)
		else begin
			fail_count++;
			$error("busy fell while tx was low");
		end

	write_sets_busy: assert property (@(posedge clk) disable iff (reset)
		(write && !busy) |=> busy)
		else begin
			fail_count++;
			$error("busy did not rise after an accepted write");
		end

endmodule

bind uart_tx_top uart_tx_assert uart_tx_assert_0 (
	.clk(clk),
	.reset(reset),
	.write(write),
	.busy(busy),
	.tx(tx)
);

//--- testbench/uart_tx_input.txt
# columns: rate select (0..7), data byte (hex), pause flag, extra-write flag,
# expected 11-bit frame (hex, bit 0 is the start bit)
7 55 0 0 4aa
6 a3 0 0 546
5 0f 0 0 41e
4 81 0 0 502
3 37 0 0 66e
7 c4 1 0 788
6 5a 0 1 4b4
2 ff 0 0 5fe
1 01 0 0 602
0 80 0 0 700
5 3c 1 0 478
4 00 0 1 400
7 e7 1 1 5ce
6 96 0 0 52c
3 aa 1 0 554
4 7e 0 1 4fc

//--- testbench/uart_tx_tb.sv
`timescale 1ns/1ps

module uart_tx_tb;

	import uart_tx_pkg::*;

	localparam int unsigned clk_hz = 1_843_200;
	localparam int pause_cycles = 37; // Length of one enable drop
	localparam int pause_bit = 4; // Enable drops in the middle of this bit

	logic clk;
	logic reset;
	logic [7:0] data;
	logic write;
	logic enable;
	baud_rate_e baud_select;
	logic tx;
	logic busy;

	int vec_select [$];
	logic [7:0] vec_data [$];
	bit vec_pause [$];
	bit vec_extra [$];
	logic [frame_bits-1:0] vec_frame [$];

	int cycle_limit;
	int cycle_count;

	uart_tx_top #(
		.clk_hz(clk_hz)
	) dut (
		.clk(clk),
		.reset(reset),
		.data(data),
		.write(write),
		.enable(enable),
		.baud_select(baud_select),
		.tx(tx),
		.busy(busy)
	);

	always #5 clk = ~clk;

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped on the first error");
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("FAILED at %0t: %s expected %b, got %b",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_frame(input string name, input logic [frame_bits-1:0] expected,
			input logic [frame_bits-1:0] actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("FAILED at %0t: %s expected %b, got %b",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_state(input string name, input tx_state_e expected,
			input tx_state_e actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("FAILED at %0t: %s expected %s, got %s",
				$time, name, expected.name(), actual.name()));
		end
	endtask

	// Outputs are sampled and inputs driven 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic hold_busy_cycles(input int count);
		repeat (count) begin
			next_cycle();
			check_bit("busy", 1'b1, busy);
		end
	endtask

	// Start bit, data LSB first, even parity, stop bit
	function automatic logic [frame_bits-1:0] frame_for(input logic [7:0] value);
		logic parity;
		parity = 1'b0;
		for (int i = 0; i < 8; i++) begin
			parity = parity ^ value[i];
		end
		return {1'b1, parity, value, 1'b0};
	endfunction

	task automatic read_vectors();
		int fd;
		int code;
		int sel;
		int pause;
		int extra;
		int div;
		logic [7:0] value;
		logic [frame_bits-1:0] frame;
		string line;
		fd = $fopen("testbench/uart_tx_input.txt", "r");
		if (fd == 0) begin
			stop_with_failure("Could not open testbench/uart_tx_input.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2 || line[0] == "#") begin
				continue;
			end
			code = $sscanf(line, "%d %h %d %d %h", sel, value, pause, extra, frame);
			if (code != 5) begin
				stop_with_failure({"Malformed line in the vector file: ", line});
			end
			vec_select.push_back(sel);
			vec_data.push_back(value);
			vec_pause.push_back(pause != 0);
			vec_extra.push_back(extra != 0);
			vec_frame.push_back(frame);
		end
		$fclose(fd);
		if (vec_data.size() == 0) begin
			stop_with_failure("The vector file holds no vectors");
		end
		cycle_limit = 100; // Reset and the first idle check
		foreach (vec_data[i]) begin
			div = baud_divisor(clk_hz, baud_rate_e'(vec_select[i][2:0]));
			cycle_limit += frame_bits * ticks_per_bit * div + 40;
			if (vec_pause[i]) begin
				cycle_limit += pause_cycles + ticks_per_bit * div;
			end
		end
	endtask

	task automatic run_vector(input int idx);
		int div;
		int bit_period;
		int length;
		int low;
		int high;
		int gap;
		logic held;
		logic [frame_bits-1:0] decoded;
		baud_rate_e rate;
		rate = baud_rate_e'(vec_select[idx][2:0]);
		div = baud_divisor(clk_hz, rate);
		bit_period = ticks_per_bit * div;
		check_frame("frame in vector file", frame_for(vec_data[idx]), vec_frame[idx]);
		baud_select = rate;
		while (busy) begin
			next_cycle();
		end
		data = vec_data[idx];
		write = 1'b1;
		next_cycle(); // Accepting edge
		write = 1'b0;
		check_bit("busy", 1'b1, busy);
		check_state("shifter state", idle, dut.uart_tx_shifter_0.state);
		if (vec_extra[idx]) begin
			data = ~vec_data[idx]; // Stays up for the whole frame and must never be accepted
			write = 1'b1;
		end
		next_cycle();
		check_state("shifter state", sending, dut.uart_tx_shifter_0.state);
		check_bit("tx start bit edge", 1'b0, tx);
		length = 0;
		for (int i = 0; i < frame_bits; i++) begin
			if (i == 0) begin
				hold_busy_cycles(bit_period / 2);
				length += bit_period / 2;
			end else begin
				hold_busy_cycles(bit_period);
				length += bit_period;
			end
			decoded[i] = tx;
			if (vec_pause[idx] && i == pause_bit) begin
				held = tx;
				enable = 1'b0;
				repeat (pause_cycles) begin
					next_cycle();
					check_bit("tx during pause", held, tx);
					check_bit("busy", 1'b1, busy);
				end
				enable = 1'b1;
				hold_busy_cycles(bit_period / 2); // The paused bit runs a full period again
				check_bit("tx after pause", held, tx);
				length += pause_cycles + bit_period / 2;
			end
		end
		while (busy) begin
			next_cycle();
			length++;
		end
		write = 1'b0;
		check_bit("tx after frame", 1'b1, tx);
		check_state("shifter state", idle, dut.uart_tx_shifter_0.state);
		check_frame("frame on tx", vec_frame[idx], decoded);
		low = frame_bits * bit_period - div - 2;
		high = frame_bits * bit_period + 2;
		if (vec_pause[idx]) begin
			low += pause_cycles;
			high += pause_cycles + bit_period;
		end
		if (length < low || length > high) begin
			stop_with_failure($sformatf("Frame %0d lasted %0d cycles, outside %0d to %0d",
				idx, length, low, high));
		end
		gap = int'($urandom_range(20, 0));
		if (vec_extra[idx]) begin
			gap += 4; // Room to see that no second frame starts
		end
		repeat (gap) begin
			next_cycle();
			check_bit("tx while idle", 1'b1, tx);
			check_bit("busy while idle", 1'b0, busy);
		end
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			stop_with_failure($sformatf("Timeout after %0d cycles", cycle_limit));
		end
		if (dut.uart_tx_assert_0.fail_count != 0) begin
			stop_with_failure("An assertion on the tx line failed");
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		data = 8'h00;
		write = 1'b0;
		enable = 1'b1;
		baud_select = baud_115200;
		cycle_count = 0;
		void'($urandom(42));
		read_vectors();
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (10) begin
			next_cycle();
			check_bit("tx after reset", 1'b1, tx);
			check_bit("busy after reset", 1'b0, busy);
		end
		foreach (vec_data[i]) begin
			run_vector(i);
		end
		if (dut.uart_tx_assert_0.fail_count == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			stop_with_failure("An assertion on the tx line failed");
		end
	end

endmodule

//--- uart_tx/uart_tx_framer.sv
`timescale 1ns/1ps

module uart_tx_framer (
	input logic clk,
	input logic reset,
	input logic [7:0] data,
	input logic write,
	input logic busy,
	output uart_tx_pkg::tx_frame_t frame
);

	import uart_tx_pkg::*;

	logic accept;
	logic parity;
	logic valid_q;
	logic [frame_bits-1:0] next_bits;
	logic [frame_bits-1:0] bits_q;

	assign accept = write && !busy; // Writes during a frame are dropped
	assign parity = ^data; // Even parity

	// Frame layout, LSB leaves the line first
	always_comb begin
		next_bits[0] = 1'b0; // Start bit
		for (int i = 0; i < 8; i++) begin
			next_bits[i + 1] = data[i];
		end
		next_bits[frame_bits - 2] = parity;
		next_bits[frame_bits - 1] = 1'b1; // Stop bit
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= accept; // One cycle pulse per accepted write
		end
	end

	// Bits stay put until the next accepted write
	always_ff @(posedge clk) begin
		if (accept) begin
			bits_q <= next_bits;
		end
	end

	assign frame = '{valid: valid_q, bits: bits_q};

endmodule

//--- uart_tx/uart_tx_shifter.sv
`timescale 1ns/1ps

module uart_tx_shifter (
	input logic clk,
	input logic reset,
	input uart_tx_pkg::tx_frame_t frame,
	input logic enable,
	input logic sample_tick,
	output logic tx,
	output logic busy
);

	import uart_tx_pkg::*;

	tx_state_e state;
	tx_state_e state_next;
	logic [3:0] tick_count;
	logic [3:0] tick_count_next;
	logic [3:0] bit_index;
	logic [3:0] bit_index_next;
	logic [frame_bits-1:0] shift_reg;
	logic load;
	logic bit_done;
	logic last_bit;

	assign load = (state == idle) && frame.valid;
	assign last_bit = (bit_index == 4'(frame_bits - 1)); // Stop bit on the line
	assign bit_done = (state == sending) && enable && sample_tick
		&& (tick_count == 4'(ticks_per_bit - 1));

	always_comb begin
		state_next = state;
		tick_count_next = tick_count;
		bit_index_next = bit_index;
		case (state)
			idle: begin
				tick_count_next = '0;
				bit_index_next = '0;
				if (frame.valid) begin
					state_next = sending;
				end
			end
			sending: begin
				if (!enable) begin
					tick_count_next = '0; // Paused, the current bit starts over
				end else if (sample_tick) begin
					tick_count_next = tick_count + 1'b1; // Wraps to zero after the last tick
				end
				if (bit_done) begin
					if (last_bit) begin
						state_next = idle;
						bit_index_next = '0;
					end else begin
						bit_index_next = bit_index + 1'b1;
					end
				end
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= idle;
			tick_count <= '0;
			bit_index <= '0;
		end else begin
			state <= state_next;
			tick_count <= tick_count_next;
			bit_index <= bit_index_next;
		end
	end

	// Shift right so that bit 0 always holds the bit on the line
	always_ff @(posedge clk) begin
		if (load) begin
			shift_reg <= frame.bits;
		end else if (bit_done) begin
			shift_reg <= {1'b1, shift_reg[frame_bits-1:1]};
		end
	end

	// tx only changes at a bit boundary, so it holds its level during a pause
	assign tx = (state == sending) ? shift_reg[0] : 1'b1;

	// frame.valid covers the cycle between the write and the load
	assign busy = (state == sending) || frame.valid;

endmodule
